/* bench/tb_models.sv */
//######################################
// Testbench models: a two-stage read pipe used
// for every memory, and a fixed-latency
// butterfly that answers top then bottom.
//######################################
`timescale 1ns/1ps

module rd_pipe #(
  parameter int w = 32
) (
  input  logic          cr_intf,
  input  logic          rst,
  input  logic          rden,
  input  logic [w-1:0]  din,
  output logic [w-1:0]  dout,
  output logic          valid
);

  logic          vld_q;
  logic [w-1:0]  dat_q;

  always_ff @(posedge cr_intf)
  begin
    if (rst)
    begin
      vld_q <= 1'b0;
      valid <= 1'b0;
    end
    else
    begin
      vld_q <= rden;
      valid <= vld_q;   // Data two cycles after the strobe
    end
    dat_q <= din;
    dout  <= dat_q;
  end

endmodule

module bfly_model (
  input  logic               cr_intf,
  input  logic               rst,
  input  fgy_pkg::but_req_t  req,
  input  logic               force_ovf,
  output fgy_pkg::but_rsp_t  rsp
);

  import fgy_pkg::*;

  localparam int lat = 5;

  logic   vld [lat];
  cplx_t  top_d [lat];
  cplx_t  bot_d [lat];
  logic   pend;
  cplx_t  bot_q;

  // a plus or minus b times w, product scaled by 2^-15
  function automatic cplx_t twiddle_mac(cplx_t a, cplx_t b, twdl_t w, logic neg);
    logic signed [63:0] pr;
    logic signed [63:0] pi;
    cplx_t r;
    pr   = b.re * w.re - b.im * w.im;
    pi   = b.re * w.im + b.im * w.re;
    r.re = neg ? a.re - 32'(pr >>> 15) : a.re + 32'(pr >>> 15);
    r.im = neg ? a.im - 32'(pi >>> 15) : a.im + 32'(pi >>> 15);
    return r;
  endfunction

  always_ff @(posedge cr_intf)
  begin
    if (rst)
    begin
      for (int i = 0; i < lat; i++)
        vld[i] <= 1'b0;
      pend <= 1'b0;
      rsp  <= '0;
    end
    else
    begin
      vld[0]   <= req.valid;
      top_d[0] <= twiddle_mac(req.sample_a, req.sample_b, req.twdl, 1'b0);
      bot_d[0] <= twiddle_mac(req.sample_a, req.sample_b, req.twdl, 1'b1);
      for (int i = 1; i < lat; i++)
      begin
        vld[i]   <= vld[i-1];
        top_d[i] <= top_d[i-1];
        bot_d[i] <= bot_d[i-1];
      end
      if (vld[lat-1])
      begin
        rsp   <= '{valid: 1'b1, res: top_d[lat-1], ovrflw: force_ovf};
        bot_q <= bot_d[lat-1];
        pend  <= 1'b1;
      end
      else if (pend)
      begin
        rsp  <= '{valid: 1'b1, res: bot_q, ovrflw: force_ovf};   // Bottom one cycle later
        pend <= 1'b0;
      end
      else
        rsp <= '0;
    end
  end

endmodule

/* bench/tb_top.sv */
//######################################
// Testbench for the FFT sequencer. Runs register,
// enable, two full frames and overflow tests
// against a reference FFT schedule.
//######################################
`timescale 1ns/1ps

module tb_top;

  import fgy_pkg::*;

  logic                     cr_intf;
  logic                     rst;
  logic                     pcm_rdy;
  logic                     force_ovf;
  lb_req_t                  lb_req;
  lb_rsp_t                  lb_rsp;
  logic [samp_addr_w-1:0]   pcm_raddr;
  logic                     pcm_rden;
  logic [data_w-1:0]        pcm_l_rdata;
  logic [data_w-1:0]        pcm_r_rdata;
  logic                     pcm_rd_valid;
  logic [samp_addr_w-1:0]   win_raddr;
  logic                     win_rden;
  logic [twdl_w-1:0]        win_rdata;
  logic                     win_rd_valid;
  logic [samp_addr_w-1:0]   twdl_raddr;
  logic                     twdl_rden;
  twdl_t                    twdl_rdata;
  logic                     twdl_rd_valid;
  logic [cache_addr_w-1:0]  cache_raddr;
  logic                     cache_rden;
  cplx_t                    cache_rdata;
  logic                     cache_rd_valid;
  cache_wr_t                cache_wr;
  but_req_t                 but_req;
  but_rsp_t                 but_rsp;
  logic                     fft_done;

  logic [data_w-1:0]  pcm_l [num_samples];
  logic [data_w-1:0]  pcm_r [num_samples];
  logic [twdl_w-1:0]  win_mem [num_samples];
  twdl_t              tw_mem [num_samples];
  cplx_t              cache_mem [2*num_samples];
  cplx_t              ref_c [2*num_samples];

  logic [cache_addr_w-1:0]  exp_rd [$];
  logic [samp_addr_w-1:0]   exp_tw [$];
  logic [71:0]              exp_wr [$];   // Address over data

  int     errors = 0;
  int     seed = 48;
  int     dec_k;
  int     fft_rd;
  int     wr_total;
  int     done_cnt;
  logic   frame_ok = 1'b0;
  logic   in_frame = 1'b0;
  logic   fin_d = 1'b0;
  string  cur_test = "init";

  fgy_top dut0 (
    .cr_intf(cr_intf), .rst(rst), .pcm_rdy(pcm_rdy), .lb_req(lb_req), .lb_rsp(lb_rsp),
    .pcm_raddr(pcm_raddr), .pcm_rden(pcm_rden), .pcm_l_rdata(pcm_l_rdata),
    .pcm_r_rdata(pcm_r_rdata), .pcm_rd_valid(pcm_rd_valid),
    .win_raddr(win_raddr), .win_rden(win_rden), .win_rdata(win_rdata),
    .win_rd_valid(win_rd_valid), .twdl_raddr(twdl_raddr), .twdl_rden(twdl_rden),
    .twdl_rdata(twdl_rdata), .twdl_rd_valid(twdl_rd_valid),
    .cache_raddr(cache_raddr), .cache_rden(cache_rden), .cache_rdata(cache_rdata),
    .cache_rd_valid(cache_rd_valid), .cache_wr(cache_wr),
    .but_req(but_req), .but_rsp(but_rsp), .fft_done(fft_done)
  );

  rd_pipe #(data_w) pcm_l_pipe (.cr_intf(cr_intf), .rst(rst), .rden(pcm_rden),
    .din(pcm_l[pcm_raddr]), .dout(pcm_l_rdata), .valid(pcm_rd_valid));
  rd_pipe #(data_w) pcm_r_pipe (.cr_intf(cr_intf), .rst(rst), .rden(pcm_rden),
    .din(pcm_r[pcm_raddr]), .dout(pcm_r_rdata), .valid());
  rd_pipe #(twdl_w) win_pipe (.cr_intf(cr_intf), .rst(rst), .rden(win_rden),
    .din(win_mem[win_raddr]), .dout(win_rdata), .valid(win_rd_valid));
  rd_pipe #(2*twdl_w) twdl_pipe (.cr_intf(cr_intf), .rst(rst), .rden(twdl_rden),
    .din(tw_mem[twdl_raddr]), .dout(twdl_rdata), .valid(twdl_rd_valid));
  rd_pipe #(2*data_w) cache_pipe (.cr_intf(cr_intf), .rst(rst), .rden(cache_rden),
    .din(cache_mem[cache_raddr]), .dout(cache_rdata), .valid(cache_rd_valid));
  bfly_model bfly0 (.cr_intf(cr_intf), .rst(rst), .req(but_req),
    .force_ovf(force_ovf), .rsp(but_rsp));

  always @(posedge cr_intf)
  begin
    if (cache_wr.wr_en)
      cache_mem[cache_wr.waddr] <= cache_wr.wr_sample;
  end

  initial
  begin
    cr_intf = 1'b0;
    forever #5 cr_intf = ~cr_intf;
  end

  function automatic logic [6:0] bitrev(logic [6:0] v);
    logic [6:0] r;
    for (int i = 0; i < 7; i++)
      r[i] = v[6-i];
    return r;
  endfunction

  function automatic cplx_t ref_mac(cplx_t a, cplx_t b, twdl_t w, logic neg);
    logic signed [63:0] pr;
    logic signed [63:0] pi;
    cplx_t r;
    pr   = b.re * w.re - b.im * w.im;
    pi   = b.re * w.im + b.im * w.re;
    r.re = neg ? a.re - 32'(pr >>> 15) : a.re + 32'(pr >>> 15);
    r.im = neg ? a.im - 32'(pi >>> 15) : a.im + 32'(pi >>> 15);
    return r;
  endfunction

  task automatic note_error(string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic check_eq(string what, logic [63:0] exp, logic [63:0] act);
    assert (exp === act)
    else
    begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report(string name, int err_before);
    $display("test %s: %s (%0d errors)", name, (errors == err_before) ? "ok" : "failed",
             errors - err_before);
  endtask

  // Expected frame schedule of decimation writes and in-place stages per channel
  task automatic build_expect();
    cplx_t b;
    cplx_t t;
    twdl_t w;
    int ta;
    int tb;
    int ti;
    int o;
    int br;
    exp_rd.delete();
    exp_tw.delete();
    exp_wr.delete();
    for (int k = 0; k < 2*num_samples; k++)
    begin
      br = bitrev(7'(k));
      b  = '{re: (k < num_samples) ? pcm_l[br] : pcm_r[br], im: '0};
      w  = '{re: win_mem[br], im: '0};
      ref_c[k] = ref_mac('0, b, w, 1'b0);
      exp_wr.push_back({8'(k), ref_c[k]});
    end
    for (int ch = 0; ch < 2; ch++)
      for (int s = 0; s < fft_stages; s++)
        for (int bf = 0; bf < num_samples/2; bf++)
        begin
          o  = bf & ((1 << s) - 1);
          ta = ch*num_samples + ((bf >> s) << (s + 1)) + o;
          tb = ta + (1 << s);
          ti = o << (fft_stages - 1 - s);
          exp_rd.push_back(8'(ta));
          exp_rd.push_back(8'(tb));
          exp_tw.push_back(7'(ti));
          t         = ref_mac(ref_c[ta], ref_c[tb], tw_mem[ti], 1'b0);
          ref_c[tb] = ref_mac(ref_c[ta], ref_c[tb], tw_mem[ti], 1'b1);
          ref_c[ta] = t;
          exp_wr.push_back({8'(ta), ref_c[ta]});
          exp_wr.push_back({8'(tb), ref_c[tb]});
        end
  endtask

  // Output monitor on every rising edge
  always @(posedge cr_intf)
  begin : monitor
    logic [71:0] w;
    logic [7:0]  a;
    if (!rst)
    begin
      if (pcm_rden)
      begin
        assert (frame_ok) else note_error("PCM read while enable was low");
        check_eq("pcm_raddr", bitrev(7'(dec_k)), pcm_raddr);
        check_eq("win_raddr", bitrev(7'(dec_k)), win_raddr);
        dec_k++;
      end
      if (cache_rden)
      begin
        if (exp_rd.size() == 0)
          note_error("cache read beyond the FFT schedule");
        else
        begin
          a = exp_rd.pop_front();
          check_eq("cache_raddr", a, cache_raddr);
          assert (wr_total - 2*num_samples >= num_samples * (fft_rd / num_samples))
          else note_error("stage read before all writes of the previous stage");
          fft_rd++;
        end
      end
      if (twdl_rden)
      begin
        if (exp_tw.size() == 0)
          note_error("twiddle read beyond the FFT schedule");
        else
          check_eq("twdl_raddr", exp_tw.pop_front(), twdl_raddr);
      end
      assert (fft_done === fin_d) else note_error("fft_done not on the clock after the last write");
      fin_d = 1'b0;
      if (cache_wr.wr_en)
      begin
        if (exp_wr.size() == 0)
          note_error("cache write beyond the frame schedule");
        else
        begin
          w     = exp_wr.pop_front();
          fin_d = (exp_wr.size() == 0);
          check_eq("cache waddr", w[71:64], cache_wr.waddr);
          check_eq("cache data", w[63:0], cache_wr.wr_sample);
          wr_total++;
        end
      end
      if (fft_done)
      begin
        in_frame = 1'b0;
        done_cnt++;
      end
      if (in_frame)
        assert (dut0.busy) else note_error("busy dropped during a frame");
      if (pcm_rden)
        in_frame = 1'b1;
    end
  end

  wr_ack_lat: assert property (@(posedge cr_intf) disable iff (rst)
                               lb_rsp.wr_valid == $past(lb_req.wr_en, 2))
    else note_error("write acknowledge not exactly two cycles after the strobe");
  rd_ack_lat: assert property (@(posedge cr_intf) disable iff (rst)
                               lb_rsp.rd_valid == $past(lb_req.rd_en, 2))
    else note_error("read acknowledge not exactly two cycles after the strobe");

  task automatic bus_write(logic [lb_addr_w-1:0] addr, logic [lb_data_w-1:0] data);
    int i;
    @(posedge cr_intf);
    lb_req <= '{wr_en: 1'b1, rd_en: 1'b0, addr: addr, wr_data: data};
    @(posedge cr_intf);
    lb_req <= '0;
    for (i = 0; i < 10; i++)
    begin
      @(posedge cr_intf);
      if (lb_rsp.wr_valid)
        break;
    end
    if (i == 10)
      note_error("timed out waiting for wr_valid");
  endtask

  task automatic bus_read(logic [lb_addr_w-1:0] addr, output logic [lb_data_w-1:0] data);
    int i;
    data = '0;
    @(posedge cr_intf);
    lb_req <= '{wr_en: 1'b0, rd_en: 1'b1, addr: addr, wr_data: '0};
    @(posedge cr_intf);
    lb_req <= '0;
    for (i = 0; i < 10; i++)
    begin
      @(posedge cr_intf);
      if (lb_rsp.rd_valid)
        break;
    end
    if (i == 10)
      note_error("timed out waiting for rd_valid");
    else
      data = lb_rsp.rd_data;
  endtask

  task automatic run_frame();
    logic [lb_data_w-1:0] d;
    int i;
    build_expect();
    dec_k    = 0;
    fft_rd   = 0;
    wr_total = 0;
    done_cnt = 0;
    frame_ok = 1'b1;
    @(posedge cr_intf);
    pcm_rdy <= 1'b1;
    @(posedge cr_intf);
    pcm_rdy <= 1'b0;
    for (i = 0; i < 100; i++)
    begin
      @(posedge cr_intf);
      if (pcm_rden)
        break;
    end
    if (i == 100)
      note_error("frame did not start");
    bus_read(status_reg_addr, d);
    check_eq("status busy bit", 1, d[0]);
    for (i = 0; i < 20000; i++)
    begin
      @(posedge cr_intf);
      if (fft_done)
        break;
    end
    if (i == 20000)
      note_error("timed out waiting for fft_done");
    repeat (10) @(posedge cr_intf);
    check_eq("fft_done pulses", 1, done_cnt);
    check_eq("writes left", 0, exp_wr.size());
    check_eq("reads left", 0, exp_rd.size());
    frame_ok = 1'b0;
  endtask

  initial
  begin
    repeat (60000) @(posedge cr_intf);
    $display("Simulation watchdog expired");
    $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    logic [lb_data_w-1:0] d;
    int e0;
    rst       = 1'b1;
    pcm_rdy   = 1'b0;
    force_ovf = 1'b0;
    lb_req    = '0;
    for (int i = 0; i < num_samples; i++)
    begin
      pcm_l[i]   = $random(seed);
      pcm_r[i]   = $random(seed);
      win_mem[i] = 16'($random(seed));
      tw_mem[i]  = twdl_t'($random(seed));
    end
    repeat (16) @(posedge cr_intf);
    rst <= 1'b0;

    cur_test = "registers";
    e0 = errors;
    bus_read(status_reg_addr, d);
    check_eq("idle status", 0, d);
    bus_read(12'h7F0, d);
    check_eq("unmapped read", bad_addr_data, d);
    bus_write(ctrl_reg_addr, 32'h0);
    bus_read(ctrl_reg_addr, d);
    check_eq("ctrl read-back", 0, d);
    report(cur_test, e0);

    cur_test = "enable_low";   // pcm_rdy alone must not start a frame
    e0 = errors;
    @(posedge cr_intf);
    pcm_rdy <= 1'b1;
    repeat (40) @(posedge cr_intf);
    pcm_rdy <= 1'b0;
    bus_read(status_reg_addr, d);
    check_eq("status with enable low", 0, d);
    report(cur_test, e0);

    cur_test = "enable_write";
    e0 = errors;
    bus_write(ctrl_reg_addr, 32'h1);
    bus_read(ctrl_reg_addr, d);
    check_eq("ctrl read-back", 1, d);
    report(cur_test, e0);

    cur_test = "frame";
    e0 = errors;
    run_frame();
    bus_read(status_reg_addr, d);
    check_eq("status after frame", 0, d);
    report(cur_test, e0);

    cur_test = "overflow";
    e0 = errors;
    force_ovf <= 1'b1;
    run_frame();
    force_ovf <= 1'b0;
    bus_read(status_reg_addr, d);
    check_eq("status after overflow", 2, d);
    repeat (20) @(posedge cr_intf);
    bus_read(status_reg_addr, d);
    check_eq("sticky overflow", 2, d);
    report(cur_test, e0);

    $display("Checks done: %0d errors", errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* source/fgy_decim_addr.sv */
//######################################
// Decimation and windowing phase. Reads both PCM
// channels bit-reversed, feeds the butterfly
// and writes top results linearly to the cache.
//######################################
`timescale 1ns/1ps

module fgy_decim_addr (
  input  logic                              cr_intf,
  input  logic                              rst,
  input  fgy_pkg::fgy_state_e               state,
  input  logic [fgy_pkg::data_w-1:0]        pcm_l_rdata,
  input  logic [fgy_pkg::data_w-1:0]        pcm_r_rdata,
  input  logic                              pcm_rd_valid,
  input  logic [fgy_pkg::twdl_w-1:0]        win_rdata,
  input  logic                              win_rd_valid,
  input  fgy_pkg::but_rsp_t                 but_rsp,
  output logic [fgy_pkg::samp_addr_w-1:0]   pcm_raddr,
  output logic                              pcm_rden,
  output logic [fgy_pkg::samp_addr_w-1:0]   win_raddr,
  output logic                              win_rden,
  output fgy_pkg::but_req_t                 dec_but_req,
  output fgy_pkg::cache_wr_t                dec_cache_wr,
  output logic                              decim_done
);

  import fgy_pkg::*;

  logic                     in_decim;
  logic                     rd_issue;
  logic [cache_addr_w-1:0]  rd_cnt;     // MSB selects the channel
  logic                     rd_gap;
  logic                     rd_end;
  logic [mem_rd_lat-1:0]    chan_dly;
  logic                     rsp_bot;
  logic                     wr_en_q;
  logic [cache_addr_w-1:0]  wr_cnt;
  cplx_t                    wr_sample_q;

  assign in_decim = (state == decim_s);
  assign rd_issue = in_decim & ~rd_gap & ~rd_end;   // One read every second cycle

  // Bit-reversed sample index
  always_comb
  begin
    for (int i = 0; i < samp_addr_w; i++)
    begin
      pcm_raddr[i] = rd_cnt[samp_addr_w-1-i];
    end
  end

  assign win_raddr = pcm_raddr;
  assign pcm_rden  = rd_issue;
  assign win_rden  = rd_issue;

  always_ff @(posedge cr_intf)
  begin
    if (rst || !in_decim)
    begin
      rd_cnt   <= '0;
      rd_gap   <= 1'b0;
      rd_end   <= 1'b0;
      chan_dly <= '0;
    end
    else
    begin
      rd_gap   <= ~rd_gap;
      chan_dly <= {chan_dly[mem_rd_lat-2:0], rd_cnt[cache_addr_w-1]};
      if (rd_issue)
      begin
        rd_cnt <= rd_cnt + 1'b1;
        rd_end <= (rd_cnt == cache_addr_w'(2 * num_samples - 1));
      end
    end
  end

  // Sample times window, with a zero top input
  always_ff @(posedge cr_intf)
  begin
    if (rst)
      dec_but_req.valid <= 1'b0;
    else
    begin
      dec_but_req.valid       <= in_decim & pcm_rd_valid & win_rd_valid;
      dec_but_req.sample_a    <= '0;
      dec_but_req.sample_b.re <= chan_dly[mem_rd_lat-1] ? pcm_r_rdata : pcm_l_rdata;
      dec_but_req.sample_b.im <= '0;
      dec_but_req.twdl.re     <= win_rdata;
      dec_but_req.twdl.im     <= '0;
    end
  end

  // Bottom results are dropped
  always_ff @(posedge cr_intf)
  begin
    if (rst || !in_decim)
    begin
      rsp_bot <= 1'b0;
      wr_en_q <= 1'b0;
      wr_cnt  <= '0;
    end
    else
    begin
      if (but_rsp.valid)
        rsp_bot <= ~rsp_bot;
      wr_en_q <= but_rsp.valid & ~rsp_bot;
      if (wr_en_q)
        wr_cnt <= wr_cnt + 1'b1;
    end
  end

  always_ff @(posedge cr_intf)
  begin
    wr_sample_q <= but_rsp.res;
  end

  assign dec_cache_wr = '{wr_en: wr_en_q, waddr: wr_cnt, wr_sample: wr_sample_q};
  assign decim_done   = wr_en_q & (&wr_cnt);   // Cache write 255

endmodule

/* source/fgy_fft_addr.sv */
//######################################
// FFT phase addressing. Walks channel, stage and
// butterfly, pairs the two cache reads into one
// request and writes results back in place.
//######################################
`timescale 1ns/1ps

module fgy_fft_addr (
  input  logic                              cr_intf,
  input  logic                              rst,
  input  fgy_pkg::fgy_state_e               state,
  input  fgy_pkg::cplx_t                    cache_rdata,
  input  logic                              cache_rd_valid,
  input  fgy_pkg::twdl_t                    twdl_rdata,
  input  logic                              twdl_rd_valid,
  input  fgy_pkg::but_rsp_t                 but_rsp,
  output logic [fgy_pkg::cache_addr_w-1:0]  cache_raddr,
  output logic                              cache_rden,
  output logic [fgy_pkg::samp_addr_w-1:0]   twdl_raddr,
  output logic                              twdl_rden,
  output fgy_pkg::but_req_t                 fft_but_req,
  output fgy_pkg::cache_wr_t                fft_cache_wr,
  output logic                              fft_all_done
);

  import fgy_pkg::*;

  logic                    in_fft;
  logic                    chan;
  logic [stage_w-1:0]      stage;
  logic [bfly_w-1:0]       rd_bfly;
  logic [bfly_w-1:0]       wr_bfly;
  logic                    rd_bot;
  logic                    wr_bot;
  logic                    rd_wait;    // Stage read out, waiting on writes
  logic [samp_addr_w-1:0]  span;
  logic [samp_addr_w-1:0]  rd_top;
  logic [samp_addr_w-1:0]  wr_top;
  logic [samp_addr_w-1:0]  rd_off;
  logic                    stage_wr_last;
  logic                    pair_bot;
  cplx_t                   top_q;
  twdl_t                   twdl_q;
  logic                    wr_en_q;
  cplx_t                   wr_sample_q;

  // Top index of butterfly b in stage s
  function automatic logic [samp_addr_w-1:0] top_idx(input logic [stage_w-1:0] s,
                                                     input logic [bfly_w-1:0]  b);
    logic [samp_addr_w-1:0] bx;
    logic [samp_addr_w-1:0] mask;
    bx      = samp_addr_w'(b);
    mask    = (samp_addr_w'(1) << s) - 1'b1;
    top_idx = ((bx >> s) << (s + 1)) | (bx & mask);
  endfunction

  assign in_fft = (state == fft_s);
  assign span   = samp_addr_w'(1) << stage;
  assign rd_top = top_idx(stage, rd_bfly);
  assign wr_top = top_idx(stage, wr_bfly);
  assign rd_off = samp_addr_w'(rd_bfly) & (span - 1'b1);

  assign cache_rden  = in_fft & ~rd_wait;
  assign cache_raddr = {chan, rd_bot ? rd_top + span : rd_top};
  assign twdl_rden   = cache_rden & ~rd_bot;   // With the top read only
  assign twdl_raddr  = rd_off << (fft_stages - 1 - stage);

  always_ff @(posedge cr_intf)
  begin
    if (rst || !in_fft)
    begin
      rd_bot  <= 1'b0;
      rd_bfly <= '0;
      rd_wait <= 1'b0;
    end
    else if (!rd_wait)
    begin
      rd_bot <= ~rd_bot;
      if (rd_bot)
      begin
        rd_bfly <= rd_bfly + 1'b1;
        rd_wait <= &rd_bfly;
      end
    end
    else if (stage_wr_last)
      rd_wait <= 1'b0;
  end

  // The butterfly keeps order, so write-back replays the read sequence
  assign stage_wr_last = wr_en_q & wr_bot & (&wr_bfly);
  assign fft_all_done  = stage_wr_last & chan & (stage == stage_w'(fft_stages - 1));

  always_ff @(posedge cr_intf)
  begin
    if (rst || !in_fft)
    begin
      stage   <= '0;
      chan    <= 1'b0;
      wr_bot  <= 1'b0;
      wr_bfly <= '0;
      wr_en_q <= 1'b0;
    end
    else
    begin
      wr_en_q <= but_rsp.valid;
      if (wr_en_q)
      begin
        wr_bot <= ~wr_bot;
        if (wr_bot)
          wr_bfly <= wr_bfly + 1'b1;
      end
      if (stage_wr_last)
      begin
        if (stage == stage_w'(fft_stages - 1))
        begin
          stage <= '0;
          chan  <= ~chan;
        end
        else
          stage <= stage + 1'b1;
      end
    end
  end

  // Hold top sample and twiddle until the bottom sample lands
  always_ff @(posedge cr_intf)
  begin
    if (cache_rd_valid && !pair_bot)
      top_q <= cache_rdata;
    if (twdl_rd_valid)
      twdl_q <= twdl_rdata;
    wr_sample_q <= but_rsp.res;
  end

  always_ff @(posedge cr_intf)
  begin
    if (rst || !in_fft)
    begin
      pair_bot          <= 1'b0;
      fft_but_req.valid <= 1'b0;
    end
    else
    begin
      if (cache_rd_valid)
        pair_bot <= ~pair_bot;
      fft_but_req.valid <= cache_rd_valid & pair_bot;
    end
    fft_but_req.sample_a <= top_q;
    fft_but_req.sample_b <= cache_rdata;
    fft_but_req.twdl     <= twdl_q;
  end

  assign fft_cache_wr = '{wr_en: wr_en_q,
                          waddr: {chan, wr_bot ? wr_top + span : wr_top},
                          wr_sample: wr_sample_q};

endmodule

/* source/fgy_pkg.sv */
//######################################
// Shared sizes, bus map, FSM states and packed
// bus types for the FFT sequencer. Every module
// imports this package.
//######################################

package fgy_pkg;

  localparam int num_samples  = 128;  // Points per channel
  localparam int fft_stages   = 7;
  localparam int stage_w      = 3;
  localparam int bfly_w       = 6;    // 64 butterflies per stage
  localparam int samp_addr_w  = 7;
  localparam int cache_addr_w = 8;    // Channel bit on top
  localparam int data_w       = 32;
  localparam int twdl_w       = 16;
  localparam int mem_rd_lat   = 2;
  localparam int lb_addr_w    = 12;
  localparam int lb_data_w    = 32;
  localparam int lb_lat       = 2;

  // Register map
  localparam logic [lb_addr_w-1:0] ctrl_reg_addr   = 12'h000;
  localparam logic [lb_addr_w-1:0] status_reg_addr = 12'h001;
  localparam logic [lb_data_w-1:0] bad_addr_data   = 32'hDEADBABE;

  typedef enum logic [1:0] {
    idle_s,
    decim_s,
    fft_s
  } fgy_state_e;

  typedef struct packed {
    logic signed [data_w-1:0] re;
    logic signed [data_w-1:0] im;
  } cplx_t;

  typedef struct packed {
    logic signed [twdl_w-1:0] re;
    logic signed [twdl_w-1:0] im;
  } twdl_t;

  typedef struct packed {
    logic                 wr_en;
    logic                 rd_en;
    logic [lb_addr_w-1:0] addr;
    logic [lb_data_w-1:0] wr_data;
  } lb_req_t;

  typedef struct packed {
    logic                 wr_valid;
    logic                 rd_valid;
    logic [lb_data_w-1:0] rd_data;
  } lb_rsp_t;

  typedef struct packed {
    logic  valid;
    cplx_t sample_a;
    cplx_t sample_b;
    twdl_t twdl;
  } but_req_t;

  // Two valid pulses per request, top result first
  typedef struct packed {
    logic  valid;
    cplx_t res;
    logic  ovrflw;
  } but_rsp_t;

  typedef struct packed {
    logic                    wr_en;
    logic [cache_addr_w-1:0] waddr;
    cplx_t                   wr_sample;
  } cache_wr_t;

endpackage

/* source/fgy_regs.sv */
//######################################
// Local bus register block. Control holds the
// enable bit, status gives busy and the sticky
// butterfly overflow. Acks come lb_lat later.
//######################################
`timescale 1ns/1ps

module fgy_regs (
  input  logic              cr_intf,
  input  logic              rst,
  input  fgy_pkg::lb_req_t  lb_req,
  input  logic              busy,
  input  logic              but_ovrflw,
  output fgy_pkg::lb_rsp_t  lb_rsp,
  output logic              fgy_en
);

  import fgy_pkg::*;

  logic [lb_lat-2:0]     wr_dly;
  logic [lb_lat-2:0]     rd_dly;
  logic [lb_addr_w-1:0]  addr_dly [lb_lat-1];
  logic [lb_addr_w-1:0]  rd_addr;
  logic                  ovrflw_flag;   // Cleared only by reset
  logic                  wr_valid_q;
  logic                  rd_valid_q;
  logic [lb_data_w-1:0]  rd_data_q;

  assign rd_addr = addr_dly[lb_lat-2];

  always_ff @(posedge cr_intf)
  begin
    if (rst)
    begin
      wr_dly      <= '0;
      rd_dly      <= '0;
      wr_valid_q  <= 1'b0;
      rd_valid_q  <= 1'b0;
      fgy_en      <= 1'b0;
      ovrflw_flag <= 1'b0;
    end
    else
    begin
      wr_dly[0] <= lb_req.wr_en;
      rd_dly[0] <= lb_req.rd_en;
      for (int i = 1; i < lb_lat - 1; i++)
      begin
        wr_dly[i] <= wr_dly[i-1];
        rd_dly[i] <= rd_dly[i-1];
      end
      wr_valid_q <= wr_dly[lb_lat-2];   // Last stage of the ack delay
      rd_valid_q <= rd_dly[lb_lat-2];

      if (lb_req.wr_en && (lb_req.addr == ctrl_reg_addr))
        fgy_en <= lb_req.wr_data[0];

      ovrflw_flag <= ovrflw_flag | but_ovrflw;
    end
  end

  // Read data follows the delayed address
  always_ff @(posedge cr_intf)
  begin
    addr_dly[0] <= lb_req.addr;
    for (int i = 1; i < lb_lat - 1; i++)
    begin
      addr_dly[i] <= addr_dly[i-1];
    end

    case (rd_addr)
      ctrl_reg_addr   : rd_data_q <= {{(lb_data_w-1){1'b0}}, fgy_en};
      status_reg_addr : rd_data_q <= {{(lb_data_w-2){1'b0}}, ovrflw_flag, busy};
      default         : rd_data_q <= bad_addr_data;
    endcase
  end

  assign lb_rsp = '{wr_valid: wr_valid_q, rd_valid: rd_valid_q, rd_data: rd_data_q};

endmodule

/* source/fgy_seq_fsm.sv */
//######################################
// Phase FSM: idle, decimation, FFT, idle.
// Registers the one-cycle fft_done pulse.
//######################################
`timescale 1ns/1ps

module fgy_seq_fsm (
  input  logic                 cr_intf,
  input  logic                 rst,
  input  logic                 fgy_en,
  input  logic                 pcm_rdy,
  input  logic                 decim_done,
  input  logic                 fft_all_done,
  output fgy_pkg::fgy_state_e  state,
  output logic                 busy,
  output logic                 fft_done
);

  import fgy_pkg::*;

  fgy_state_e next_state;

  always_comb
  begin
    next_state = state;
    case (state)
      idle_s  : if (fgy_en && pcm_rdy) next_state = decim_s;
      decim_s : if (decim_done) next_state = fft_s;
      fft_s   : if (fft_all_done) next_state = idle_s;
      default : next_state = idle_s;
    endcase
  end

  always_ff @(posedge cr_intf)
  begin
    if (rst)
    begin
      state    <= idle_s;
      fft_done <= 1'b0;
    end
    else
    begin
      state    <= next_state;
      fft_done <= (state == fft_s) & fft_all_done;  // Same edge as the return to idle
    end
  end

  assign busy = (state != idle_s);

endmodule

/* source/fgy_top.sv */
//######################################
// FFT sequencer top. Connects registers, FSM and
// both address blocks; muxes butterfly and cache
// write ports by phase.
//######################################
`timescale 1ns/1ps

module fgy_top (
  input  logic                              cr_intf,
  input  logic                              rst,
  input  logic                              pcm_rdy,
  input  fgy_pkg::lb_req_t                  lb_req,
  output fgy_pkg::lb_rsp_t                  lb_rsp,
  output logic [fgy_pkg::samp_addr_w-1:0]   pcm_raddr,
  output logic                              pcm_rden,
  input  logic [fgy_pkg::data_w-1:0]        pcm_l_rdata,
  input  logic [fgy_pkg::data_w-1:0]        pcm_r_rdata,
  input  logic                              pcm_rd_valid,
  output logic [fgy_pkg::samp_addr_w-1:0]   win_raddr,
  output logic                              win_rden,
  input  logic [fgy_pkg::twdl_w-1:0]        win_rdata,
  input  logic                              win_rd_valid,
  output logic [fgy_pkg::samp_addr_w-1:0]   twdl_raddr,
  output logic                              twdl_rden,
  input  fgy_pkg::twdl_t                    twdl_rdata,
  input  logic                              twdl_rd_valid,
  output logic [fgy_pkg::cache_addr_w-1:0]  cache_raddr,
  output logic                              cache_rden,
  input  fgy_pkg::cplx_t                    cache_rdata,
  input  logic                              cache_rd_valid,
  output fgy_pkg::cache_wr_t                cache_wr,
  output fgy_pkg::but_req_t                 but_req,
  input  fgy_pkg::but_rsp_t                 but_rsp,
  output logic                              fft_done
);

  import fgy_pkg::*;

  fgy_state_e  state;
  logic        busy;
  logic        fgy_en;
  logic        decim_done;
  logic        fft_all_done;
  logic        but_ovrflw;
  but_req_t    dec_but_req;
  but_req_t    fft_but_req;
  cache_wr_t   dec_cache_wr;
  cache_wr_t   fft_cache_wr;

  assign but_ovrflw = but_rsp.valid & but_rsp.ovrflw;

  fgy_regs regs0 (
    .cr_intf(cr_intf), .rst(rst), .lb_req(lb_req), .busy(busy),
    .but_ovrflw(but_ovrflw), .lb_rsp(lb_rsp), .fgy_en(fgy_en)
  );

  fgy_seq_fsm fsm0 (
    .cr_intf(cr_intf), .rst(rst), .fgy_en(fgy_en), .pcm_rdy(pcm_rdy),
    .decim_done(decim_done), .fft_all_done(fft_all_done),
    .state(state), .busy(busy), .fft_done(fft_done)
  );

  fgy_decim_addr decim0 (
    .cr_intf(cr_intf), .rst(rst), .state(state),
    .pcm_l_rdata(pcm_l_rdata), .pcm_r_rdata(pcm_r_rdata), .pcm_rd_valid(pcm_rd_valid),
    .win_rdata(win_rdata), .win_rd_valid(win_rd_valid), .but_rsp(but_rsp),
    .pcm_raddr(pcm_raddr), .pcm_rden(pcm_rden), .win_raddr(win_raddr),
    .win_rden(win_rden), .dec_but_req(dec_but_req), .dec_cache_wr(dec_cache_wr),
    .decim_done(decim_done)
  );

  fgy_fft_addr fft0 (
    .cr_intf(cr_intf), .rst(rst), .state(state),
    .cache_rdata(cache_rdata), .cache_rd_valid(cache_rd_valid),
    .twdl_rdata(twdl_rdata), .twdl_rd_valid(twdl_rd_valid), .but_rsp(but_rsp),
    .cache_raddr(cache_raddr), .cache_rden(cache_rden), .twdl_raddr(twdl_raddr),
    .twdl_rden(twdl_rden), .fft_but_req(fft_but_req), .fft_cache_wr(fft_cache_wr),
    .fft_all_done(fft_all_done)
  );

  // Phase muxes
  assign but_req  = (state == fft_s) ? fft_but_req : dec_but_req;
  assign cache_wr = (state == decim_s) ? dec_cache_wr : fft_cache_wr;

endmodule

/* tb.f */
source/fgy_pkg.sv
source/fgy_regs.sv
source/fgy_seq_fsm.sv
source/fgy_decim_addr.sv
source/fgy_fft_addr.sv
source/fgy_top.sv
bench/tb_models.sv
bench/tb_top.sv
